// File: Bender.yml
package:
  name: ace_snoop_unit

sources:
  - source/ace_pkg.sv
  - source/ace_ar_transaction_decoder.sv
  - source/snoop_result_if.sv
  - source/ace_snoop_sequencer.sv
  - source/ace_cr_collector.sv
  - source/ace_snoop_unit.sv
  - target: test
    files:
      - tb/tb_ace_snoop_unit.sv

// File: list.f
source/ace_pkg.sv
source/ace_ar_transaction_decoder.sv
source/snoop_result_if.sv
source/ace_snoop_sequencer.sv
source/ace_cr_collector.sv
source/ace_snoop_unit.sv
tb/tb_ace_snoop_unit.sv

// File: source/ace_ar_transaction_decoder.sv
module ace_ar_transaction_decoder import ace_pkg::*; (
    input  ar_chan_t ar_i,
    output acsnoop_t acsnoop_o,
    output logic     illegal_trs_o,
    output logic     needs_snoop_o
);

    logic shareable;
    logic system_domain;
    logic barrier_bar;

    logic no_snoop_read;
    logic shareable_trs;
    logic cache_maint;
    logic barrier_trs;

    // ==========================================================
    // Field classification
    // ==========================================================

    assign shareable     = ar_i.domain inside {InnerShareable, OuterShareable};
    assign system_domain = ar_i.domain == System;

    // MemoryBarrierIgnore behaves as a normal access
    assign barrier_bar = ar_i.bar inside {MemoryBarrier, SynchronizationBarrier};

    // ==========================================================
    // Legal combinations
    // ==========================================================

    assign no_snoop_read = !barrier_bar && !shareable && ar_i.snoop == ReadNoSnoop;

    // Reads, unique requests and DVM need an inner or outer domain
    assign shareable_trs = !barrier_bar && shareable &&
                           ar_i.snoop inside {ReadOnce, ReadShared, ReadClean,
                                              ReadNotSharedDirty, ReadUnique,
                                              CleanUnique, MakeUnique,
                                              DVMComplete, DVMMessage};

    // Cache maintenance in any domain but System
    assign cache_maint = !barrier_bar && !system_domain &&
                         ar_i.snoop inside {CleanShared, CleanInvalid, MakeInvalid};

    assign barrier_trs = barrier_bar && ar_i.snoop == Barrier;

    assign illegal_trs_o = !(no_snoop_read || shareable_trs || cache_maint || barrier_trs);

    // Only the snooped classes go out on AC
    assign needs_snoop_o = shareable_trs || cache_maint;

    // ==========================================================
    // ARSNOOP to ACSNOOP
    // ==========================================================

    always_comb begin
        case (ar_i.snoop)
            CleanUnique: begin
                acsnoop_o = SnpCleanInvalid;
            end
            MakeUnique: begin
                acsnoop_o = SnpMakeInvalid;
            end
            default: begin
                // Remaining snooped codes are identical on AC
                acsnoop_o = acsnoop_t'(ar_i.snoop);
            end
        endcase
    end

endmodule

// File: source/ace_cr_collector.sv
module ace_cr_collector import ace_pkg::*; #(
    parameter int unsigned num_snoopers = 2
)(
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    snoop_result_if.col                 res,
    // CR channel
    input  logic     [num_snoopers-1:0] cr_valid_i,
    output logic     [num_snoopers-1:0] cr_ready_o,
    input  cr_resp_t [num_snoopers-1:0] cr_resp_i
);

    logic                    collecting_q;
    logic                    done_q;
    logic [num_snoopers-1:0] resp_seen_q;
    logic [num_snoopers-1:0] cr_hs;
    logic [num_snoopers-1:0] seen_next;
    cr_resp_t                merged_q;
    cr_resp_t                merged_next;

    // Each snooper is ready until its single response is in
    assign cr_ready_o = collecting_q ? ~resp_seen_q : '0;
    assign cr_hs      = cr_valid_i & cr_ready_o;
    assign seen_next  = resp_seen_q | cr_hs;

    always_comb begin
        merged_next = merged_q;
        for (int i = 0; i < num_snoopers; i++) begin
            if (cr_hs[i]) begin
                merged_next = merged_next | cr_resp_i[i];
            end
        end
    end

    // ==========================================================
    // Collection control
    // ==========================================================

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            collecting_q <= 1'b0;
            done_q       <= 1'b0;
            resp_seen_q  <= '0;
        end else begin
            done_q <= 1'b0;
            if (res.start) begin
                collecting_q <= 1'b1;
                resp_seen_q  <= '0;
            end else if (collecting_q) begin
                resp_seen_q <= seen_next;
                if (&seen_next) begin
                    collecting_q <= 1'b0;
                    done_q       <= 1'b1;
                end
            end
        end
    end

    // Merged flags stay put once collection ends
    always_ff @(posedge clk_i) begin
        if (res.start) begin
            merged_q <= '0;
        end else if (collecting_q) begin
            merged_q <= merged_next;
        end
    end

    assign res.done          = done_q;
    assign res.data_transfer = merged_q.data_transfer;
    assign res.is_shared     = merged_q.is_shared;
    assign res.pass_dirty    = merged_q.pass_dirty;
    assign res.error         = merged_q.error;

    for (genvar i = 0; i < num_snoopers; i++) begin : g_single_resp
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            collecting_q && resp_seen_q[i] |-> !cr_valid_i[i])
            else $error("Second CR response from snooper %0d", i);
    end

endmodule

// File: source/ace_pkg.sv
package ace_pkg;

    // AR and AC address width
    localparam int unsigned addr_width = 64;

    // ==========================================================
    // Snoop opcodes
    // ==========================================================

    // ARSNOOP encodings, domain and bar tell the code 0 users apart
    typedef enum logic [3:0] {
        ReadNoSnoop        = 4'b0000,
        ReadShared         = 4'b0001,
        ReadClean          = 4'b0010,
        ReadNotSharedDirty = 4'b0011,
        ReadUnique         = 4'b0111,
        CleanShared        = 4'b1000,
        CleanInvalid       = 4'b1001,
        CleanUnique        = 4'b1011,
        MakeUnique         = 4'b1100,
        MakeInvalid        = 4'b1101,
        DVMComplete        = 4'b1110,
        DVMMessage         = 4'b1111
    } arsnoop_t;

    // Aliases of code 0
    localparam arsnoop_t ReadOnce = ReadNoSnoop;
    localparam arsnoop_t Barrier  = ReadNoSnoop;

    // ACSNOOP encodings as seen by the snooping caches
    typedef enum logic [3:0] {
        SnpReadOnce           = 4'b0000,
        SnpReadShared         = 4'b0001,
        SnpReadClean          = 4'b0010,
        SnpReadNotSharedDirty = 4'b0011,
        SnpReadUnique         = 4'b0111,
        SnpCleanShared        = 4'b1000,
        SnpCleanInvalid       = 4'b1001,
        SnpMakeInvalid        = 4'b1101,
        SnpDVMComplete        = 4'b1110,
        SnpDVMMessage         = 4'b1111
    } acsnoop_t;

    // ==========================================================
    // AR field encodings
    // ==========================================================

    typedef enum logic [1:0] {
        NonShareable   = 2'b00,
        InnerShareable = 2'b01,
        OuterShareable = 2'b10,
        System         = 2'b11
    } domain_t;

    typedef enum logic [1:0] {
        NormalAccess           = 2'b00,
        MemoryBarrier          = 2'b01,
        MemoryBarrierIgnore    = 2'b10,
        SynchronizationBarrier = 2'b11
    } bar_t;

    // AR payload
    typedef struct packed {
        logic [addr_width-1:0] addr;
        arsnoop_t              snoop;
        domain_t               domain;
        bar_t                  bar;
        logic [3:0]            id;
    } ar_chan_t;

    // CRRESP, bit 0 is DataTransfer
    typedef struct packed {
        logic was_unique;
        logic is_shared;
        logic pass_dirty;
        logic error;
        logic data_transfer;
    } cr_resp_t;

    // Snoop sequencer states
    typedef enum logic [1:0] {
        idle,
        decide,
        snoop,
        respond
    } seq_state_t;

endpackage

// File: source/ace_snoop_sequencer.sv
module ace_snoop_sequencer import ace_pkg::*; #(
    parameter int unsigned num_snoopers = 2
)(
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    // AR channel
    input  logic                    ar_valid_i,
    output logic                    ar_ready_o,
    input  ar_chan_t                ar_i,
    // AC channel
    output logic [num_snoopers-1:0] ac_valid_o,
    input  logic [num_snoopers-1:0] ac_ready_i,
    output logic [addr_width-1:0]   ac_addr_o,
    output acsnoop_t                ac_snoop_o,
    // Collector
    snoop_result_if.seq             res,
    // Result
    output logic                    rsp_valid_o,
    output logic                    rsp_err_o,
    output logic                    rsp_data_o,
    output logic                    rsp_shared_o,
    output logic                    rsp_dirty_o,
    output logic                    rsp_mem_fetch_o
);

    seq_state_t              state_q;
    seq_state_t              state_d;
    ar_chan_t                ar_q;
    acsnoop_t                acsnoop;
    logic                    illegal_trs;
    logic                    needs_snoop;
    logic                    is_read;
    logic                    ar_hs;
    logic [num_snoopers-1:0] ac_pending_q;

    logic rsp_err_q;
    logic rsp_data_q;
    logic rsp_shared_q;
    logic rsp_dirty_q;
    logic rsp_mem_fetch_q;

    ace_ar_transaction_decoder decoder_inst (
        .ar_i          (ar_q),
        .acsnoop_o     (acsnoop),
        .illegal_trs_o (illegal_trs),
        .needs_snoop_o (needs_snoop)
    );

    assign ar_ready_o = state_q == idle;
    assign ar_hs      = ar_valid_i && ar_ready_o;

    // Legal reads fetch from memory unless a cache supplied the line
    assign is_read = !illegal_trs &&
                     !(ar_q.bar inside {MemoryBarrier, SynchronizationBarrier}) &&
                     ar_q.snoop inside {ReadNoSnoop, ReadShared, ReadClean,
                                        ReadNotSharedDirty, ReadUnique};

    assign res.start = state_q == decide && needs_snoop;

    // ==========================================================
    // State machine
    // ==========================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            idle: begin
                if (ar_hs) begin
                    state_d = decide;
                end
            end
            decide: begin
                state_d = needs_snoop ? snoop : respond;
            end
            snoop: begin
                if (res.done) begin
                    state_d = respond;
                end
            end
            default: begin
                state_d = idle;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= idle;
            ac_pending_q <= '0;
        end else begin
            state_q <= state_d;
            if (res.start) begin
                ac_pending_q <= '1;
            end else begin
                ac_pending_q <= ac_pending_q & ~ac_ready_i;
            end
        end
    end

    // AR payload, held for the whole transaction
    always_ff @(posedge clk_i) begin
        if (ar_hs) begin
            ar_q <= ar_i;
        end
    end

    // ==========================================================
    // Result capture
    // ==========================================================

    always_ff @(posedge clk_i) begin
        if (state_q == decide && !needs_snoop) begin
            rsp_err_q       <= illegal_trs;
            rsp_data_q      <= 1'b0;
            rsp_shared_q    <= 1'b0;
            rsp_dirty_q     <= 1'b0;
            rsp_mem_fetch_q <= is_read;
        end else if (state_q == snoop && res.done) begin
            rsp_err_q       <= res.error;
            rsp_data_q      <= res.data_transfer;
            rsp_shared_q    <= res.is_shared;
            rsp_dirty_q     <= res.pass_dirty;
            rsp_mem_fetch_q <= is_read && !res.data_transfer && !res.error;
        end
    end

    assign ac_valid_o = ac_pending_q;
    assign ac_addr_o  = ar_q.addr;
    assign ac_snoop_o = acsnoop;

    assign rsp_valid_o     = state_q == respond;
    assign rsp_err_o       = rsp_err_q;
    assign rsp_data_o      = rsp_data_q;
    assign rsp_shared_o    = rsp_shared_q;
    assign rsp_dirty_o     = rsp_dirty_q;
    assign rsp_mem_fetch_o = rsp_mem_fetch_q;

    // ==========================================================
    // Assertions
    // ==========================================================

    for (genvar i = 0; i < num_snoopers; i++) begin : g_ac_hold
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            ac_valid_o[i] && !ac_ready_i[i] |=>
                ac_valid_o[i] && $stable(ac_addr_o) && $stable(ac_snoop_o))
            else $error("AC %0d dropped or changed before ready", i);
    end

    // An illegal request never reaches the snoopers
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        state_q == decide && illegal_trs |=> (ac_valid_o == '0) until (state_q == idle))
        else $error("AC issued for an illegal transaction");

endmodule

// File: source/ace_snoop_unit.sv
module ace_snoop_unit import ace_pkg::*; #(
    parameter int unsigned num_snoopers = 2
)(
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    // AR channel
    input  logic                        ar_valid_i,
    output logic                        ar_ready_o,
    input  ar_chan_t                    ar_i,
    // AC channel
    output logic     [num_snoopers-1:0] ac_valid_o,
    input  logic     [num_snoopers-1:0] ac_ready_i,
    output logic     [addr_width-1:0]   ac_addr_o,
    output acsnoop_t                    ac_snoop_o,
    // CR channel
    input  logic     [num_snoopers-1:0] cr_valid_i,
    output logic     [num_snoopers-1:0] cr_ready_o,
    input  cr_resp_t [num_snoopers-1:0] cr_resp_i,
    // Merged result
    output logic                        rsp_valid_o,
    output logic                        rsp_err_o,
    output logic                        rsp_data_o,
    output logic                        rsp_shared_o,
    output logic                        rsp_dirty_o,
    output logic                        rsp_mem_fetch_o
);

    snoop_result_if res_if ();

    ace_snoop_sequencer #(
        .num_snoopers (num_snoopers)
    ) sequencer_inst (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .ar_valid_i      (ar_valid_i),
        .ar_ready_o      (ar_ready_o),
        .ar_i            (ar_i),
        .ac_valid_o      (ac_valid_o),
        .ac_ready_i      (ac_ready_i),
        .ac_addr_o       (ac_addr_o),
        .ac_snoop_o      (ac_snoop_o),
        .res             (res_if.seq),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_err_o       (rsp_err_o),
        .rsp_data_o      (rsp_data_o),
        .rsp_shared_o    (rsp_shared_o),
        .rsp_dirty_o     (rsp_dirty_o),
        .rsp_mem_fetch_o (rsp_mem_fetch_o)
    );

    ace_cr_collector #(
        .num_snoopers (num_snoopers)
    ) collector_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .res        (res_if.col),
        .cr_valid_i (cr_valid_i),
        .cr_ready_o (cr_ready_o),
        .cr_resp_i  (cr_resp_i)
    );

endmodule

// File: source/snoop_result_if.sv
interface snoop_result_if ();

    // Pulse as the AC broadcast begins
    logic start;

    // Pulse once every snooper has answered
    logic done;

    // Merged CR flags, valid with done
    logic data_transfer;
    logic is_shared;
    logic pass_dirty;
    logic error;

    modport seq (
        output start,
        input  done,
        input  data_transfer,
        input  is_shared,
        input  pass_dirty,
        input  error
    );

    modport col (
        input  start,
        output done,
        output data_transfer,
        output is_shared,
        output pass_dirty,
        output error
    );

endinterface

// File: tb/tb_ace_snoop_unit.sv
module tb_ace_snoop_unit import ace_pkg::*; ();

    localparam int num_snoopers = 2;
    localparam int num_tests    = 13;

    logic                        clk_i = 1'b0;
    logic                        rst_n_i;
    logic                        ar_valid_i;
    logic                        ar_ready_o;
    ar_chan_t                    ar_i;
    logic     [num_snoopers-1:0] ac_valid_o;
    logic     [num_snoopers-1:0] ac_ready_i;
    logic     [addr_width-1:0]   ac_addr_o;
    acsnoop_t                    ac_snoop_o;
    logic     [num_snoopers-1:0] cr_valid_i;
    logic     [num_snoopers-1:0] cr_ready_o;
    cr_resp_t [num_snoopers-1:0] cr_resp_i;
    logic                        rsp_valid_o;
    logic                        rsp_err_o;
    logic                        rsp_data_o;
    logic                        rsp_shared_o;
    logic                        rsp_dirty_o;
    logic                        rsp_mem_fetch_o;

    integer seed = 38702;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;

    // Expectations for the transaction in flight
    logic     snoop_expected;
    logic     illegal_expected;
    logic     read_expected;
    acsnoop_t exp_ac_snoop;

    // Snooper model setup and what each model returned
    int                      ac_delay [num_snoopers];
    int                      cr_delay [num_snoopers];
    cr_resp_t                resp_pick [num_snoopers];
    cr_resp_t                sent_resp [num_snoopers];
    cr_resp_t                resp_table [6];
    logic [num_snoopers-1:0] cr_taken;

    cr_resp_t                merged_exp;
    logic                    exp_err;
    logic                    exp_data;
    logic                    exp_fetch;
    logic                    ar_hs;
    logic [num_snoopers-1:0] cr_hs;
    logic                    cr_last_hs;
    logic                    rsp_trigger;

    ace_snoop_unit #(
        .num_snoopers (num_snoopers)
    ) ace_snoop_unit_inst (.*);

    always #5 clk_i = ~clk_i;

    always_comb begin
        merged_exp = '0;
        for (int i = 0; i < num_snoopers; i++) begin
            merged_exp = merged_exp | sent_resp[i];
        end
    end

    assign exp_err   = snoop_expected ? merged_exp.error : illegal_expected;
    assign exp_data  = snoop_expected && merged_exp.data_transfer;
    assign exp_fetch = read_expected && !exp_data && !exp_err;

    assign ar_hs       = ar_valid_i && ar_ready_o;
    assign cr_hs       = cr_valid_i & cr_ready_o;
    assign cr_last_hs  = |cr_hs && ((cr_hs | cr_taken) == '1);
    assign rsp_trigger = (ar_hs && !snoop_expected) || cr_last_hs;

    task automatic value_error(input string sig, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
        errors++;
        $display("Error at %0t: %s expected %0h, got %0h", $time, sig, exp_val, act_val);
    endtask

    task automatic report_fault(input string msg);
        errors++;
        $display("Failure at %0t: %s", $time, msg);
    endtask

    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // ==========================================================
    // Checks
    // ==========================================================

    // Decide or done, then respond
    assert property (@(posedge clk_i) disable iff (!rst_n_i) rsp_valid_o == $past(rsp_trigger, 2))
        else value_error("rsp_valid_o", !$sampled(rsp_valid_o), $sampled(rsp_valid_o));
    assert property (@(posedge clk_i) disable iff (!rst_n_i) rsp_valid_o |-> rsp_err_o == exp_err)
        else value_error("rsp_err_o", exp_err, $sampled(rsp_err_o));
    assert property (@(posedge clk_i) disable iff (!rst_n_i) rsp_valid_o |-> rsp_data_o == exp_data)
        else value_error("rsp_data_o", exp_data, $sampled(rsp_data_o));
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_o |-> rsp_shared_o == (snoop_expected && merged_exp.is_shared))
        else value_error("rsp_shared_o", snoop_expected && merged_exp.is_shared,
                         $sampled(rsp_shared_o));
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_o |-> rsp_dirty_o == (snoop_expected && merged_exp.pass_dirty))
        else value_error("rsp_dirty_o", snoop_expected && merged_exp.pass_dirty,
                         $sampled(rsp_dirty_o));
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_o |-> rsp_mem_fetch_o == exp_fetch)
        else value_error("rsp_mem_fetch_o", exp_fetch, $sampled(rsp_mem_fetch_o));

    assert property (@(posedge clk_i) disable iff (!rst_n_i) !snoop_expected |-> ac_valid_o == '0)
        else value_error("ac_valid_o", 0, $sampled(ac_valid_o));
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(ar_hs && snoop_expected, 2) |-> ac_valid_o == '1)
        else value_error("ac_valid_o", {num_snoopers{1'b1}}, $sampled(ac_valid_o));
    assert property (@(posedge clk_i) disable iff (!rst_n_i) |ac_valid_o |-> ac_snoop_o == exp_ac_snoop)
        else value_error("ac_snoop_o", exp_ac_snoop, $sampled(ac_snoop_o));
    assert property (@(posedge clk_i) disable iff (!rst_n_i) |ac_valid_o |-> ac_addr_o == ar_i.addr)
        else value_error("ac_addr_o", ar_i.addr, $sampled(ac_addr_o));

    for (genvar g = 0; g < num_snoopers; g++) begin : g_ac_hold
        assert property (@(posedge clk_i) disable iff (!rst_n_i)
            ac_valid_o[g] && !ac_ready_i[g] |=>
                ac_valid_o[g] && $stable(ac_addr_o) && $stable(ac_snoop_o))
            else report_fault($sformatf("AC request %0d dropped or changed before ready", g));
    end

    // CR ready only while a snooped transaction still waits for that snooper
    assert property (@(posedge clk_i) disable iff (!rst_n_i) !snoop_expected |-> cr_ready_o == '0)
        else value_error("cr_ready_o", 0, $sampled(cr_ready_o));
    assert property (@(posedge clk_i) disable iff (!rst_n_i) (cr_ready_o & cr_taken) == '0)
        else report_fault("cr_ready_o high for a snooper that already responded");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ar_hs || (!ar_ready_o && !rsp_valid_o) |=> !ar_ready_o)
        else report_fault("ar_ready_o rose before the result was out");
    assert property (@(posedge clk_i) disable iff (!rst_n_i) rsp_valid_o |=> ar_ready_o)
        else report_fault("ar_ready_o stayed low after the result");

    // ==========================================================
    // Snooper model and test sequence
    // ==========================================================

    task automatic snooper(input int idx);
        while (!ac_valid_o[idx]) begin
            step_cycles(1);
        end
        step_cycles(ac_delay[idx]);
        ac_ready_i[idx] = 1'b1;
        step_cycles(1);
        ac_ready_i[idx] = 1'b0;
        step_cycles(cr_delay[idx]);
        cr_resp_i[idx]  = resp_pick[idx];
        cr_valid_i[idx] = 1'b1;
        sent_resp[idx]  = resp_pick[idx];
        while (!cr_ready_o[idx]) begin
            step_cycles(1);
        end
        step_cycles(1);
        cr_valid_i[idx] = 1'b0;
        cr_taken[idx]   = 1'b1;
    endtask

    task automatic run_test(input string name, input arsnoop_t snp, input domain_t dom,
                            input bar_t bar, input logic snooped, input logic illegal,
                            input acsnoop_t acs, input logic read, input int stall);
        int errors_before;
        errors_before    = errors;
        snoop_expected   = snooped;
        illegal_expected = illegal;
        read_expected    = read;
        exp_ac_snoop     = acs;
        cr_taken         = '0;
        for (int i = 0; i < num_snoopers; i++) begin
            ac_delay[i]  = $unsigned($random(seed)) % 4;
            cr_delay[i]  = $unsigned($random(seed)) % 5;
            resp_pick[i] = resp_table[$unsigned($random(seed)) % 6];
            sent_resp[i] = '0;
        end
        // Last snooper holds off AC when a stall is asked for
        ac_delay[num_snoopers-1] += stall;
        ar_i.addr   = {$random(seed), $random(seed)};
        ar_i.snoop  = snp;
        ar_i.domain = dom;
        ar_i.bar    = bar;
        ar_i.id     = 4'(tests_run);
        ar_valid_i  = 1'b1;
        while (!ar_ready_o) begin
            step_cycles(1);
        end
        step_cycles(1);
        ar_valid_i = 1'b0;
        if (snooped) begin
            fork
                snooper(0);
                snooper(1);
            join_none
        end
        while (!rsp_valid_o) begin
            step_cycles(1);
        end
        step_cycles(1);
        wait fork;
        tests_run++;
        if (errors == errors_before) begin
            tests_passed++;
            $display("Test %0d %s ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s failed", tests_run, name);
        end
    endtask

    initial begin
        rst_n_i          = 1'b0;
        ar_valid_i       = 1'b0;
        ar_i             = '0;
        ac_ready_i       = '0;
        cr_valid_i       = '0;
        cr_resp_i        = '0;
        snoop_expected   = 1'b0;
        illegal_expected = 1'b0;
        read_expected    = 1'b0;
        exp_ac_snoop     = SnpReadOnce;
        cr_taken         = '0;
        for (int i = 0; i < num_snoopers; i++) begin
            sent_resp[i] = '0;
        end
        // was_unique, is_shared, pass_dirty, error, data_transfer
        resp_table[0] = 5'b00000;
        resp_table[1] = 5'b01001;
        resp_table[2] = 5'b10101;
        resp_table[3] = 5'b01000;
        resp_table[4] = 5'b10001;
        resp_table[5] = 5'b00010;
        repeat (8) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        step_cycles(2);

        run_test("ReadNoSnoop", ReadNoSnoop, NonShareable, NormalAccess, 0, 0, SnpReadOnce, 1, 0);
        run_test("Barrier", Barrier, InnerShareable, MemoryBarrier, 0, 0, SnpReadOnce, 0, 0);
        run_test("ReadShared NonShareable", ReadShared, NonShareable, NormalAccess,
                 0, 1, SnpReadOnce, 0, 0);
        run_test("CleanShared System", CleanShared, System, NormalAccess, 0, 1, SnpReadOnce, 0, 0);
        run_test("ReadShared with barrier", ReadShared, InnerShareable, SynchronizationBarrier,
                 0, 1, SnpReadOnce, 0, 0);
        run_test("ReadShared", ReadShared, InnerShareable, NormalAccess, 1, 0, SnpReadShared, 1, 0);
        run_test("ReadUnique", ReadUnique, OuterShareable, NormalAccess, 1, 0, SnpReadUnique, 1, 0);
        run_test("CleanUnique", CleanUnique, InnerShareable, NormalAccess,
                 1, 0, SnpCleanInvalid, 0, 0);
        run_test("MakeUnique", MakeUnique, OuterShareable, NormalAccess,
                 1, 0, SnpMakeInvalid, 0, 0);
        run_test("ReadClean stalled", ReadClean, InnerShareable, NormalAccess,
                 1, 0, SnpReadClean, 1, 6);
        repeat (3) begin
            run_test("ReadNotSharedDirty", ReadNotSharedDirty, OuterShareable, NormalAccess,
                     1, 0, SnpReadNotSharedDirty, 1, 0);
        end

        $display("Tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Watchdog sized from the test count
    initial begin
        repeat (num_tests * 200 + 8) @(posedge clk_i);
        $display("Watchdog expired before the tests finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
